// File: files.f
logic/fsl_pkg.sv
logic/fsl_channel.sv
logic/fsl_dispatch.sv
logic/fsl_collect.sv
logic/fsl_hub.sv
verif/fsl_hub_tb.sv

// File: logic/fsl_channel.sv
// FSL channel FIFO pair
`timescale 1ns/1ns
`default_nettype none

module fsl_channel import fsl_pkg::*; (
   input  logic      cpu,
   input  logic      reset_i,
   // Outbound, PUT side
   input  logic      out_push_i,
   input  fsl_word_t push_word_i,
   output logic      out_full_o,
   // Outbound, accelerator side
   output logic      m_valid_o,
   output fsl_word_t m_word_o,
   input  logic      m_ready_i,
   // Inbound, GET side
   input  logic      in_pop_i,
   output fsl_word_t in_head_o,
   output logic      in_empty_o,
   // Inbound, accelerator side
   input  logic      s_valid_i,
   input  fsl_word_t s_word_i,
   output logic      s_ready_o
);

   // Bit 0 is the outbound FIFO, bit 1 the inbound one
   logic      [1:0] push;
   logic      [1:0] pop;
   logic      [1:0] full;
   logic      [1:0] empty;
   fsl_word_t [1:0] wdata;
   fsl_word_t [1:0] head;

   assign push[0]  = out_push_i;               // Dispatcher PUT
   assign wdata[0] = push_word_i;
   assign pop[0]   = m_valid_o & m_ready_i;    // Beat leaves to accelerator
   assign push[1]  = s_valid_i & s_ready_o;    // Beat taken from accelerator
   assign wdata[1] = s_word_i;
   assign pop[1]   = in_pop_i;                 // Dispatcher GET

   for (genvar d = 0; d < 2; d++) begin : g_fifo
      fsl_word_t        mem_q [FIFO_DEPTH];    // Circular storage
      logic [PTR_W-1:0] wr_ptr_q;
      logic [PTR_W-1:0] rd_ptr_q;
      logic [CNT_W-1:0] cnt_q;                 // Occupancy

      always_ff @(posedge cpu) begin
         if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
         end else begin
            if (push[d]) begin
               wr_ptr_q <= wr_ptr_q + 1'b1;    // Natural wrap, depth is 2**PTR_W
            end
            if (pop[d]) begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push[d], pop[d]})
               2'b10:   cnt_q <= cnt_q + 1'b1;
               2'b01:   cnt_q <= cnt_q - 1'b1;
               default: cnt_q <= cnt_q;        // Both or neither, level holds
            endcase
         end
      end

      always_ff @(posedge cpu) begin
         if (push[d]) begin
            mem_q[wr_ptr_q] <= wdata[d];
         end
      end

      assign head[d]  = mem_q[rd_ptr_q];       // Show-ahead head
      assign full[d]  = (cnt_q == CNT_W'(FIFO_DEPTH));
      assign empty[d] = (cnt_q == '0);
   end

   assign out_full_o = full[0];
   assign m_valid_o  = ~empty[0];              // Any queued PUT is offered
   assign m_word_o   = head[0];
   assign in_head_o  = head[1];
   assign in_empty_o = empty[1];
   assign s_ready_o  = ~full[1];               // Back-pressure when inbound full

   // Dispatcher must respect the flags it was given
   a_push_not_full: assert property (@(posedge cpu) disable iff (reset_i)
      out_push_i |-> !out_full_o)
      else $error("PUT pushed into a full outbound FIFO");

   a_pop_not_empty: assert property (@(posedge cpu) disable iff (reset_i)
      in_pop_i |-> !in_empty_o)
      else $error("GET popped an empty inbound FIFO");

endmodule

`default_nettype wire

// File: logic/fsl_collect.sv
// FSL GET data collector
`timescale 1ns/1ns
`default_nettype none

module fsl_collect import fsl_pkg::*; (
   input  logic                   cpu,
   input  logic                   reset_i,
   // Inbound heads of all channels
   input  fsl_word_t [N_CHAN-1:0] in_head_i,
   // From dispatcher
   input  logic                   rd_take_i,
   input  logic [CHAN_W-1:0]      rd_chan_i,
   input  logic                   rd_ctl_i,
   // To core
   output logic [31:0]            fsl_dat_o,
   output logic                   fsl_err_o
);

   fsl_word_t         head;      // Head of the GET channel
   logic              ctl_miss;  // Word kind differs from tag bit 0
   logic [DATA_W-1:0] dat_q;
   logic              err_q;

   assign head     = in_head_i[rd_chan_i];
   assign ctl_miss = head.ctl ^ rd_ctl_i;  // Word is consumed anyway

   // Loads on the ack edge, holds through failed GETs
   always_ff @(posedge cpu) begin
      if (rd_take_i) begin
         dat_q <= head.data;
      end
   end

   always_ff @(posedge cpu) begin
      if (reset_i) begin
         err_q <= 1'b0;
      end else if (rd_take_i) begin
         err_q <= ctl_miss;                // Kept until next good GET
      end
   end

   assign fsl_dat_o = dat_q;
   assign fsl_err_o = err_q;

endmodule

`default_nettype wire

// File: logic/fsl_dispatch.sv
// FSL request dispatcher
`timescale 1ns/1ns
`default_nettype none

module fsl_dispatch import fsl_pkg::*; (
   input  logic                cpu,
   input  logic                reset_i,
   // Core request
   input  logic                fsl_stb_i,
   input  logic                fsl_wre_i,
   input  logic [6:2]          fsl_adr_i,
   input  logic [1:0]          fsl_tag_i,
   input  logic [31:0]         fsl_dat_i,
   // Channel status
   input  logic [N_CHAN-1:0]   out_full_i,
   input  logic [N_CHAN-1:0]   in_empty_i,
   // Channel controls
   output logic [N_CHAN-1:0]   out_push_o,
   output fsl_word_t           push_word_o,
   output logic [N_CHAN-1:0]   in_pop_o,
   // Collector controls
   output logic                rd_take_o,
   output logic [CHAN_W-1:0]   rd_chan_o,
   output logic                rd_ctl_o,
   // Core response
   output logic                fsl_ack_o,
   output logic                fsl_fail_o
);

   link_state_e       state_q;
   fsl_req_t          req_q;     // Latched request
   fsl_op_e           op;        // Decoded operation
   logic              is_put;    // Outbound FIFO is the resource
   logic              nonblk;    // Ends on first check, pass or fail
   logic              can_go;    // Room for PUT or data for GET
   logic              finish;    // Ack at the coming edge
   logic [N_CHAN-1:0] chan_sel;  // One-hot target
   logic              ack_q;
   logic              fail_q;
   logic [N_CHAN-1:0] push_q;
   logic [N_CHAN-1:0] pop_q;

   assign op = fsl_op_e'({req_q.wre, req_q.nblk, req_q.ctl});

   // Ctl flavour only matters to the data path
   always_comb begin
      case (op)
         GET, CGET: begin
            is_put = 1'b0;
            nonblk = 1'b0;
         end
         NGET, NCGET: begin
            is_put = 1'b0;
            nonblk = 1'b1;
         end
         PUT, CPUT: begin
            is_put = 1'b1;
            nonblk = 1'b0;
         end
         NPUT, NCPUT: begin
            is_put = 1'b1;
            nonblk = 1'b1;
         end
         default: begin
            is_put = 1'b0;
            nonblk = 1'b0;
         end
      endcase
   end

   assign chan_sel = N_CHAN'(1) << req_q.chan;
   assign can_go   = is_put ? ~out_full_i[req_q.chan] : ~in_empty_i[req_q.chan];
   assign finish   = (state_q == WAIT) && (can_go || nonblk);  // Blocking ops stall here

   // Fields are stable while stb is up
   always_ff @(posedge cpu) begin
      if (state_q == IDLE && fsl_stb_i) begin
         req_q.chan <= fsl_adr_i[3:2];    // Four channels, low index bits
         req_q.wre  <= fsl_wre_i;
         req_q.nblk <= fsl_tag_i[1];
         req_q.ctl  <= fsl_tag_i[0];
         req_q.data <= fsl_dat_i;
      end
   end

   always_ff @(posedge cpu) begin
      if (reset_i) begin
         state_q <= IDLE;
         ack_q   <= 1'b0;
         fail_q  <= 1'b0;
         push_q  <= '0;
         pop_q   <= '0;
      end else begin
         ack_q  <= finish;
         fail_q <= finish && !can_go;                        // Only non-blocking reach this
         push_q <= (finish && can_go && is_put) ? chan_sel : '0;
         pop_q  <= (finish && can_go && !is_put) ? chan_sel : '0;
         case (state_q)
            IDLE:    if (fsl_stb_i) state_q <= WAIT;
            WAIT:    if (finish) state_q <= DONE;
            DONE:    state_q <= IDLE;                        // Old stb still high here
            default: state_q <= IDLE;
         endcase
      end
   end

   assign fsl_ack_o   = ack_q;
   assign fsl_fail_o  = fail_q;
   assign out_push_o  = push_q;                  // Lands in FIFO at end of ack cycle
   assign in_pop_o    = pop_q;
   assign push_word_o = '{ctl: req_q.ctl, data: req_q.data};
   assign rd_take_o   = finish && can_go && !is_put;  // Head sampled on ack edge
   assign rd_chan_o   = req_q.chan;
   assign rd_ctl_o    = req_q.ctl;

   a_ack_pulse: assert property (@(posedge cpu) disable iff (reset_i)
      fsl_ack_o |=> !fsl_ack_o)
      else $error("ack held longer than one cycle");

   // Exactly one FIFO move per good ack, none otherwise
   a_move_with_ack: assert property (@(posedge cpu) disable iff (reset_i)
      (|out_push_o || |in_pop_o) |-> (fsl_ack_o && !fsl_fail_o && $onehot({out_push_o, in_pop_o})))
      else $error("FIFO push or pop without a good ack");

endmodule

`default_nettype wire

// File: logic/fsl_hub.sv
// FSL channel hub top
`timescale 1ns/1ns
`default_nettype none

module fsl_hub import fsl_pkg::*; (
   input  logic                   cpu,
   input  logic                   reset_i,
   // Core FSL port, hub is slave
   input  logic                   fsl_stb_i,
   input  logic                   fsl_wre_i,
   input  logic [6:2]             fsl_adr_i,
   input  logic [1:0]             fsl_tag_i,
   input  logic [31:0]            fsl_dat_i,
   output logic                   fsl_ack_o,
   output logic [31:0]            fsl_dat_o,
   output logic                   fsl_fail_o,
   output logic                   fsl_err_o,
   // Accelerator streams, hub to accelerator
   output logic      [N_CHAN-1:0] m_valid_o,
   output fsl_word_t [N_CHAN-1:0] m_word_o,
   input  logic      [N_CHAN-1:0] m_ready_i,
   // Accelerator streams, accelerator to hub
   input  logic      [N_CHAN-1:0] s_valid_i,
   input  fsl_word_t [N_CHAN-1:0] s_word_i,
   output logic      [N_CHAN-1:0] s_ready_o
);

   logic      [N_CHAN-1:0] out_full;   // Per channel status
   logic      [N_CHAN-1:0] in_empty;
   fsl_word_t [N_CHAN-1:0] in_head;
   logic      [N_CHAN-1:0] out_push;   // One-hot from dispatcher
   logic      [N_CHAN-1:0] in_pop;
   fsl_word_t              push_word;  // Shared by all channels
   logic                   rd_take;
   logic      [CHAN_W-1:0] rd_chan;
   logic                   rd_ctl;

   fsl_dispatch u_dispatch (
      .cpu         (cpu),
      .reset_i     (reset_i),
      .fsl_stb_i   (fsl_stb_i),
      .fsl_wre_i   (fsl_wre_i),
      .fsl_adr_i   (fsl_adr_i),
      .fsl_tag_i   (fsl_tag_i),
      .fsl_dat_i   (fsl_dat_i),
      .out_full_i  (out_full),
      .in_empty_i  (in_empty),
      .out_push_o  (out_push),
      .push_word_o (push_word),
      .in_pop_o    (in_pop),
      .rd_take_o   (rd_take),
      .rd_chan_o   (rd_chan),
      .rd_ctl_o    (rd_ctl),
      .fsl_ack_o   (fsl_ack_o),
      .fsl_fail_o  (fsl_fail_o)
   );

   for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
      fsl_channel u_channel (
         .cpu         (cpu),
         .reset_i     (reset_i),
         .out_push_i  (out_push[c]),
         .push_word_i (push_word),
         .out_full_o  (out_full[c]),
         .m_valid_o   (m_valid_o[c]),
         .m_word_o    (m_word_o[c]),
         .m_ready_i   (m_ready_i[c]),
         .in_pop_i    (in_pop[c]),
         .in_head_o   (in_head[c]),
         .in_empty_o  (in_empty[c]),
         .s_valid_i   (s_valid_i[c]),
         .s_word_i    (s_word_i[c]),
         .s_ready_o   (s_ready_o[c])
      );
   end

   fsl_collect u_collect (
      .cpu        (cpu),
      .reset_i    (reset_i),
      .in_head_i  (in_head),
      .rd_take_i  (rd_take),
      .rd_chan_i  (rd_chan),
      .rd_ctl_i   (rd_ctl),
      .fsl_dat_o  (fsl_dat_o),
      .fsl_err_o  (fsl_err_o)
   );

endmodule

`default_nettype wire

// File: logic/fsl_pkg.sv
// FSL hub shared definitions
`default_nettype none

package fsl_pkg;

   localparam int N_CHAN     = 4;   // Channels behind the hub
   localparam int CHAN_W     = 2;   // Channel index, fsl_adr_i[3:2]
   localparam int DATA_W     = 32;  // FSL data word
   localparam int FIFO_DEPTH = 4;   // Entries per FIFO
   localparam int CNT_W      = 3;   // Occupancy 0..FIFO_DEPTH
   localparam int PTR_W      = 2;   // FIFO slot index, wraps at depth

   // FIFO entry and stream beat
   typedef struct packed {
      logic              ctl;       // Control word marker
      logic [DATA_W-1:0] data;      // Payload
   } fsl_word_t;

   // Request as latched from the core
   typedef struct packed {
      logic [CHAN_W-1:0] chan;      // Target channel
      logic              wre;       // PUT when set, GET otherwise
      logic              nblk;      // Tag bit 1, non-blocking
      logic              ctl;       // Tag bit 0, control access
      logic [DATA_W-1:0] data;      // PUT payload
   } fsl_req_t;

   // Coded as {wre, nblk, ctl}, same order as the core's decode table
   typedef enum logic [2:0] {
      GET   = 3'o0,
      CGET  = 3'o1,
      NGET  = 3'o2,
      NCGET = 3'o3,
      PUT   = 3'o4,
      CPUT  = 3'o5,
      NPUT  = 3'o6,
      NCPUT = 3'o7
   } fsl_op_e;

   typedef enum logic [1:0] {
      IDLE,                         // Waiting for stb
      WAIT,                         // Request held, resource check
      DONE                          // Ack cycle, stb ignored
   } link_state_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the FSL hub testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module fsl_hub_tb \
   && ./obj_dir/Vfsl_hub_tb | tee /dev/stderr | grep -q "Regression passed" \
   && echo "Simulation run passed" \
   || { echo "Simulation run failed"; exit 1; }

// File: verif/fsl_hub_tb.sv
// FSL hub testbench
`timescale 1ns/1ns
`default_nettype none

module fsl_hub_tb import fsl_pkg::*; ();

   logic                   cpu = 1'b0;
   logic                   reset_i;
   logic                   fsl_stb_i;
   logic                   fsl_wre_i;
   logic [6:2]             fsl_adr_i;
   logic [1:0]             fsl_tag_i;
   logic [31:0]            fsl_dat_i;
   logic                   fsl_ack_o;
   logic [31:0]            fsl_dat_o;
   logic                   fsl_fail_o;
   logic                   fsl_err_o;
   logic      [N_CHAN-1:0] m_valid_o;
   fsl_word_t [N_CHAN-1:0] m_word_o;
   logic      [N_CHAN-1:0] m_ready_i;
   logic      [N_CHAN-1:0] s_valid_i;
   fsl_word_t [N_CHAN-1:0] s_word_i;
   logic      [N_CHAN-1:0] s_ready_o;

   fsl_word_t              out_q [N_CHAN][$];  // Expected outbound contents
   fsl_word_t              in_q  [N_CHAN][$];  // Expected inbound contents
   int                     out_cnt [N_CHAN];   // Levels seen by the current cycle
   int                     in_cnt  [N_CHAN];
   logic      [N_CHAN-1:0] pend_push;          // Acked PUT that lands at the next edge
   logic      [N_CHAN-1:0] pend_pop;           // Acked GET that leaves at the next edge
   fsl_word_t              pend_word [N_CHAN];
   logic      [1:0]        out_mode [N_CHAN];  // 0 never ready, 1 random, 2 always
   logic      [1:0]        in_mode  [N_CHAN];  // 0 idle, 1 random, 2 always valid
   integer                 seed = 18111;
   logic      [31:0]       rnd;                // Stream driver draws
   logic      [31:0]       req_rnd;            // Request field draws
   logic      [31:0]       pick;
   logic      [N_CHAN-1:0] nxt_ready;
   logic      [N_CHAN-1:0] nxt_valid;
   fsl_word_t [N_CHAN-1:0] nxt_word;
   logic                   cur_wre;            // Request in flight
   logic      [1:0]        cur_chan;
   logic      [1:0]        cur_tag;
   logic      [31:0]       cur_dat;
   logic      [31:0]       last_dat;           // Last good GET result
   logic                   last_err;
   logic                   have_dat;

   fsl_hub DUT (
      .cpu        (cpu),
      .reset_i    (reset_i),
      .fsl_stb_i  (fsl_stb_i),
      .fsl_wre_i  (fsl_wre_i),
      .fsl_adr_i  (fsl_adr_i),
      .fsl_tag_i  (fsl_tag_i),
      .fsl_dat_i  (fsl_dat_i),
      .fsl_ack_o  (fsl_ack_o),
      .fsl_dat_o  (fsl_dat_o),
      .fsl_fail_o (fsl_fail_o),
      .fsl_err_o  (fsl_err_o),
      .m_valid_o  (m_valid_o),
      .m_word_o   (m_word_o),
      .m_ready_i  (m_ready_i),
      .s_valid_i  (s_valid_i),
      .s_word_i   (s_word_i),
      .s_ready_o  (s_ready_o)
   );

   always #2 cpu = ~cpu;  // 4 ns period

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // Accelerator stream values drawn at the edge and applied 1 ns later
   always @(posedge cpu) begin
      for (int c = 0; c < N_CHAN; c++) begin
         rnd = $random(seed);
         nxt_ready[c] = (out_mode[c] == 2'd2) || (out_mode[c] == 2'd1 && rnd[0]);
         nxt_valid[c] = (in_mode[c] == 2'd2) || (in_mode[c] == 2'd1 && rnd[2:1] == 2'b00);
         nxt_word[c].ctl  = rnd[3];
         nxt_word[c].data = $random(seed);
      end
      #1;
      m_ready_i = nxt_ready;
      s_valid_i = nxt_valid;
      s_word_i  = nxt_word;
   end

   // Mid-cycle monitor moves the model by what happens at the coming edge
   always @(negedge cpu) begin
      if (!reset_i) begin
         for (int c = 0; c < N_CHAN; c++) begin
            out_cnt[c] = out_q[c].size();  // Levels the dispatcher decides on
            in_cnt[c]  = in_q[c].size();
            check($sformatf("m_valid_o[%0d]", c), m_valid_o[c], out_cnt[c] != 0);
            check($sformatf("s_ready_o[%0d]", c), s_ready_o[c], in_cnt[c] < FIFO_DEPTH);
            if (pend_pop[c]) begin
               void'(in_q[c].pop_front());
               pend_pop[c] = 1'b0;
            end
            if (m_valid_o[c] && m_ready_i[c]) begin  // Beat leaves
               check($sformatf("m_word_o[%0d]", c), m_word_o[c], out_q[c][0]);
               void'(out_q[c].pop_front());
            end
            if (pend_push[c]) begin
               out_q[c].push_back(pend_word[c]);
               pend_push[c] = 1'b0;
            end
            if (s_valid_i[c] && s_ready_o[c]) begin  // Beat enters
               in_q[c].push_back(s_word_i[c]);
            end
         end
      end
   end

   task automatic drive_req(input logic wre, input logic [1:0] chan, input logic [1:0] tag,
                            input logic [31:0] dat);
      cur_wre   = wre;
      cur_chan  = chan;
      cur_tag   = tag;
      cur_dat   = dat;
      req_rnd   = $random(seed);
      fsl_stb_i = 1'b1;
      fsl_wre_i = wre;
      fsl_adr_i = {req_rnd[2:0], chan};  // Upper address bits not decoded
      fsl_tag_i = tag;
      fsl_dat_i = dat;
   endtask

   task automatic await_ack(input int limit, output logic got);
      int n;
      got = 1'b0;
      n = 0;
      while (!got && n < limit) begin
         @(posedge cpu);
         #1;
         n++;
         got = fsl_ack_o;
      end
   endtask

   // Called in the ack cycle
   task automatic finish_req(output logic fail);
      logic      ready;
      fsl_word_t head;
      ready = cur_wre ? (out_cnt[cur_chan] < FIFO_DEPTH) : (in_cnt[cur_chan] != 0);
      fail = fsl_fail_o;
      fsl_stb_i = 1'b0;
      if (!cur_tag[1] && !ready) begin
         abort_run($sformatf("Blocking request acked on channel %0d before it was ready",
                             cur_chan));
      end
      check("fsl_fail_o", fsl_fail_o, !ready);
      if (!cur_wre && ready) begin
         head = in_q[cur_chan][0];
         last_dat = head.data;
         last_err = head.ctl ^ cur_tag[0];  // Kind mismatch still consumes the word
         have_dat = 1'b1;
         pend_pop[cur_chan] = 1'b1;
      end else if (cur_wre && ready) begin
         pend_word[cur_chan] = '{ctl: cur_tag[0], data: cur_dat};
         pend_push[cur_chan] = 1'b1;
      end
      if (have_dat) begin
         check("fsl_dat_o", fsl_dat_o, last_dat);  // Held over failed GETs
      end
      check("fsl_err_o", fsl_err_o, last_err);
   endtask

   task automatic do_req(input logic wre, input logic [1:0] chan, input logic [1:0] tag,
                         input logic [31:0] dat, output logic fail);
      logic got;
      drive_req(wre, chan, tag, dat);
      await_ack(200, got);
      if (!got) begin
         abort_run($sformatf("Timeout waiting for ack from channel %0d", chan));
      end
      finish_req(fail);
   endtask

   task automatic wait_drain();
      int n;
      int left;
      n = 0;
      left = 1;
      for (int c = 0; c < N_CHAN; c++) out_mode[c] = 2'd2;
      while (left != 0) begin
         @(posedge cpu);
         #1;
         n++;
         if (n > 100) abort_run("Outbound FIFOs did not drain");
         left = 0;
         for (int c = 0; c < N_CHAN; c++) left += out_q[c].size() + pend_push[c];
      end
   endtask

   task automatic wait_inbound(input int chan, input int level);
      int n;
      n = 0;
      while (in_q[chan].size() < level) begin
         @(posedge cpu);
         #1;
         n++;
         if (n > 100) begin
            abort_run($sformatf("Inbound FIFO %0d stayed below %0d words", chan, level));
         end
      end
   endtask

   initial begin
      logic fail;
      logic got;
      reset_i   = 1'b1;
      fsl_stb_i = 1'b0;
      fsl_wre_i = 1'b0;
      fsl_adr_i = '0;
      fsl_tag_i = '0;
      fsl_dat_i = '0;
      m_ready_i = '0;
      s_valid_i = '0;
      s_word_i  = '0;
      pend_push = '0;
      pend_pop  = '0;
      have_dat  = 1'b0;
      last_err  = 1'b0;
      for (int c = 0; c < N_CHAN; c++) begin
         out_mode[c] = 2'd0;
         in_mode[c]  = 2'd0;
         out_cnt[c]  = 0;
         in_cnt[c]   = 0;
      end
      repeat (10) @(posedge cpu);
      #1 reset_i = 1'b0;

      // Reset values
      check("fsl_ack_o", fsl_ack_o, 1'b0);
      check("fsl_fail_o", fsl_fail_o, 1'b0);
      check("fsl_err_o", fsl_err_o, 1'b0);
      check("m_valid_o", m_valid_o, '0);
      check("s_ready_o", s_ready_o, {N_CHAN{1'b1}});

      // Blocking PUT and CPUT under random back-pressure
      for (int c = 0; c < N_CHAN; c++) out_mode[c] = 2'd1;
      for (int i = 0; i < 200; i++) begin
         pick = $random(seed);
         do_req(1'b1, pick[1:0], {1'b0, pick[2]}, $random(seed), fail);
      end
      wait_drain();
      out_mode[0] = 2'd0;                            // Channel 0 stalls
      for (int i = 0; i < FIFO_DEPTH; i++) do_req(1'b1, 2'd0, 2'b00, $random(seed), fail);
      drive_req(1'b1, 2'd0, 2'b01, $random(seed));
      await_ack(20, got);
      if (got) abort_run("PUT to a full channel was acked before a beat drained");
      out_mode[0] = 2'd2;
      await_ack(100, got);
      if (!got) abort_run("Timeout waiting for PUT after the outbound FIFO drained");
      finish_req(fail);
      wait_drain();

      // Fill every inbound FIFO, then GET and CGET them empty
      for (int c = 0; c < N_CHAN; c++) in_mode[c] = 2'd2;
      for (int c = 0; c < N_CHAN; c++) wait_inbound(c, FIFO_DEPTH);
      check("s_ready_o", s_ready_o, '0);
      for (int c = 0; c < N_CHAN; c++) in_mode[c] = 2'd0;
      for (int i = 0; i < N_CHAN * FIFO_DEPTH; i++) begin
         pick = $random(seed);
         do_req(1'b0, 2'(i % N_CHAN), {1'b0, pick[0]}, '0, fail);
      end

      // Non-blocking fail and pass cases
      wait_drain();
      out_mode[1] = 2'd0;
      for (int i = 0; i < FIFO_DEPTH; i++) do_req(1'b1, 2'd1, 2'b00, $random(seed), fail);
      do_req(1'b1, 2'd1, 2'b10, $random(seed), fail);  // NPUT into a full channel
      check("fsl_fail_o", fail, 1'b1);
      do_req(1'b1, 2'd1, 2'b11, $random(seed), fail);  // NCPUT into a full channel
      check("fsl_fail_o", fail, 1'b1);
      do_req(1'b0, 2'd2, 2'b10, '0, fail);             // NGET from an empty channel
      check("fsl_fail_o", fail, 1'b1);
      do_req(1'b0, 2'd2, 2'b11, '0, fail);             // NCGET from an empty channel
      check("fsl_fail_o", fail, 1'b1);
      do_req(1'b1, 2'd2, 2'b10, $random(seed), fail);
      check("fsl_fail_o", fail, 1'b0);
      do_req(1'b1, 2'd3, 2'b11, $random(seed), fail);
      check("fsl_fail_o", fail, 1'b0);
      in_mode[3] = 2'd2;
      wait_inbound(3, 2);
      in_mode[3] = 2'd0;
      do_req(1'b0, 2'd3, 2'b10, '0, fail);
      check("fsl_fail_o", fail, 1'b0);
      do_req(1'b0, 2'd3, 2'b11, '0, fail);
      check("fsl_fail_o", fail, 1'b0);
      wait_drain();

      // Blocking GET on an empty channel waits for an injected beat
      drive_req(1'b0, 2'd0, 2'b00, '0);
      await_ack(20, got);
      if (got) abort_run("GET on an empty channel was acked");
      in_mode[0] = 2'd2;
      await_ack(100, got);
      in_mode[0] = 2'd0;
      if (!got) abort_run("Timeout waiting for GET after the inbound beat");
      finish_req(fail);

      // Mixed traffic over all operations and channels
      for (int c = 0; c < N_CHAN; c++) begin
         out_mode[c] = 2'd1;
         in_mode[c]  = 2'd1;
      end
      for (int i = 0; i < 3000; i++) begin
         pick = $random(seed);
         do_req(pick[0], pick[2:1], pick[4:3], $random(seed), fail);
      end
      for (int c = 0; c < N_CHAN; c++) in_mode[c] = 2'd0;
      wait_drain();

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire
